/* tb.f */
+incdir+.
noc_pkg.sv
noc_addr_decode.sv
noc_route_comp.sv
noc_xy_route_select.sv
noc_out_arbiter.sv
noc_router_top.sv
tb_noc_router_top.sv

/* Bender.yml */
package:
  name: noc_router_tile

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - noc_pkg.sv
      - noc_addr_decode.sv
      - noc_route_comp.sv
      - noc_xy_route_select.sv
      - noc_out_arbiter.sv
      - noc_router_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_noc_router_top.sv

/* tb_noc_router_top.sv */
/*
 * Testbench for the mesh tile routing front end in table mode.
 * Drives random, same-direction and all-direction traffic, models the
 * XY routing and round-robin arbitration, and checks the DUT with assertions.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module tb_noc_router_top;

  import noc_pkg::*;

  localparam int unsigned NumReq = `NOC_NUM_REQ;
  localparam int unsigned NumRules = `NOC_NUM_RULES;
  // Rule coordinates in octal with x as the upper digit and y as the lower
  localparam logic [5:0] RuleDst [NumRules] = '{6'o11, 6'o12, 6'o21, 6'o10,
                                                6'o01, 6'o33, 6'o02, 6'o20};
  // Rules that route east of tile (1,1)
  localparam int unsigned EastRules [3] = '{2, 5, 7};
  // Local, north, south and west rule for requesters 0 to 3
  localparam int unsigned SplitRules [NumReq] = '{0, 1, 3, 4};

  logic                                clk;
  logic                                arst_n;
  logic               [NumReq-1:0]     req;
  addr_t              [NumReq-1:0]     req_addr;
  payload_t           [NumReq-1:0]     req_payload;
  addr_rule_t         [NumRules-1:0]   rule_map;
  logic               [NumReq-1:0]     gnt_o;
  logic               [NumDirs-1:0]    out_valid_o;
  flit_t              [NumDirs-1:0]    out_flit_o;

  // Grants seen just before the coming rising edge
  logic [NumReq-1:0] gnt_at_edge;
  logic [31:0]       rng_state;
  logic [NumDirs-1:0] dir_seen;

  // Reference model state
  xy_id_t             exp_dst [NumReq];
  route_dir_e         exp_dir [NumReq];
  req_idx_t           model_ptr [NumDirs];
  req_idx_t           exp_win [NumDirs];
  logic [NumDirs-1:0] exp_hit;
  logic [NumReq-1:0]  exp_gnt;
  logic [NumDirs-1:0] exp_valid_q;
  flit_t [NumDirs-1:0] exp_flit_q;
  int unsigned        wait_cnt [NumReq];

  noc_router_top noc_router_top_inst (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .req_i         ( req         ),
    .req_addr_i    ( req_addr    ),
    .req_payload_i ( req_payload ),
    .addr_map_i    ( rule_map    ),
    .gnt_o         ( gnt_o       ),
    .out_valid_o   ( out_valid_o ),
    .out_flit_o    ( out_flit_o  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // First rule whose half-open range holds the address
  function automatic xy_id_t lookup_dst(addr_t addr);
    xy_id_t dst;
    dst = '0;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (addr >= rule_map[i].start_addr && addr < rule_map[i].end_addr) dst = rule_map[i].idx;
    end
    return dst;
  endfunction

  // X is resolved before Y relative to this tile
  function automatic route_dir_e xy_dir(xy_id_t dst);
    if (dst.x > `NOC_LOCAL_X) return DirEast;
    if (dst.x < `NOC_LOCAL_X) return DirWest;
    if (dst.y > `NOC_LOCAL_Y) return DirNorth;
    if (dst.y < `NOC_LOCAL_Y) return DirSouth;
    return DirLocal;
  endfunction

  task automatic stop_with_failure(string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // Expected grants from the rotating pointers of the model
  always_comb begin
    int unsigned cand;
    exp_gnt = '0;
    exp_hit = '0;
    for (int unsigned r = 0; r < NumReq; r++) begin
      exp_dst[r] = lookup_dst(req_addr[r]);
      exp_dir[r] = xy_dir(exp_dst[r]);
    end
    for (int unsigned d = 0; d < NumDirs; d++) begin
      exp_win[d] = '0;
      for (int unsigned k = 0; k < NumReq; k++) begin
        cand = (int'(model_ptr[d]) + k) % NumReq;
        if (!exp_hit[d] && req[cand] && exp_dir[cand] == route_dir_e'(d)) begin
          exp_hit[d]    = 1'b1;
          exp_win[d]    = req_idx_t'(cand);
          exp_gnt[cand] = 1'b1;
        end
      end
    end
  end

  // Expected output stage lags the grant by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid_q <= '0;
      dir_seen    <= '0;
      for (int unsigned d = 0; d < NumDirs; d++) model_ptr[d] <= '0;
      for (int unsigned r = 0; r < NumReq; r++) wait_cnt[r] <= 0;
    end else begin
      dir_seen <= dir_seen | out_valid_o;
      for (int unsigned d = 0; d < NumDirs; d++) begin
        exp_valid_q[d] <= exp_hit[d];
        if (exp_hit[d]) begin
          exp_flit_q[d] <= '{dst: exp_dst[exp_win[d]], src: exp_win[d],
                             payload: req_payload[exp_win[d]]};
          model_ptr[d]  <= req_idx_t'((int'(exp_win[d]) + 1) % NumReq);
        end
      end
      // Count grants of its own direction that go to someone else
      for (int unsigned r = 0; r < NumReq; r++) begin
        if (gnt_o[r]) wait_cnt[r] <= 0;
        else if (req[r] && |(gnt_o & ~(NumReq'(1) << r))) begin
          for (int unsigned q = 0; q < NumReq; q++) begin
            if (gnt_o[q] && exp_dir[q] == exp_dir[r]) wait_cnt[r] <= wait_cnt[r] + 1;
          end
        end
      end
    end
  end

  // Quiet during reset and in the first cycle after it
  a_reset_quiet : assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |-> (out_valid_o == '0 && gnt_o == '0))
    else stop_with_failure($sformatf("FAIL at %0t ns: activity around reset, valid %b gnt %b",
                                     $time, $sampled(out_valid_o), $sampled(gnt_o)));

  a_gnt_model : assert property (@(posedge clk) disable iff (!arst_n) gnt_o == exp_gnt)
    else stop_with_failure($sformatf("FAIL at %0t ns: gnt_o %b, expected %b",
                                     $time, $sampled(gnt_o), $sampled(exp_gnt)));

  a_valid_model : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid_o == exp_valid_q)
    else stop_with_failure($sformatf("FAIL at %0t ns: out_valid_o %b, expected %b",
                                     $time, $sampled(out_valid_o), $sampled(exp_valid_q)));

  for (genvar d = 0; d < NumDirs; d++) begin : gen_flit_check
    a_flit_model : assert property (@(posedge clk) disable iff (!arst_n)
      out_valid_o[d] |-> out_flit_o[d] == exp_flit_q[d])
      else stop_with_failure($sformatf("FAIL at %0t ns: direction %0d flit %h, expected %h",
                                       $time, d, $sampled(out_flit_o[d]),
                                       $sampled(exp_flit_q[d])));
  end

  for (genvar r = 0; r < NumReq; r++) begin : gen_wait_check
    a_wait_bound : assert property (@(posedge clk) disable iff (!arst_n) wait_cnt[r] <= 3)
      else stop_with_failure($sformatf("FAIL at %0t ns: requester %0d waited %0d grants",
                                       $time, r, $sampled(wait_cnt[r])));
  end

  task automatic present_request(int unsigned r, int unsigned rule);
    addr_t span;
    span           = rule_map[rule].end_addr - rule_map[rule].start_addr;
    req[r]         = 1'b1;
    req_addr[r]    = rule_map[rule].start_addr + (next_random() % span);
    req_payload[r] = next_random();
  endtask

  // Mode 0 uses random rules and mode 1 sends everything east
  // Mode 2 gives each requester its own direction
  task automatic run_traffic(int unsigned cycles, int unsigned mode);
    logic [31:0] pick;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      for (int unsigned r = 0; r < NumReq; r++) begin
        if (!req[r] || gnt_at_edge[r]) begin
          pick = next_random();
          if (mode == 0 && pick[0]) req[r] = 1'b0;
          else if (mode == 0) present_request(r, pick[8:1] % NumRules);
          else if (mode == 1) present_request(r, EastRules[pick[8:1] % 3]);
          else present_request(r, SplitRules[r]);
        end
      end
      @(negedge clk);
      gnt_at_edge = gnt_o;
    end
  endtask

  // Drop each request once granted until none is left
  task automatic drain_requests();
    int unsigned waited;
    waited = 0;
    while (req != '0) begin
      @(posedge clk);
      #1;
      req = req & ~gnt_at_edge;
      @(negedge clk);
      gnt_at_edge = gnt_o;
      waited++;
      if (waited > 16) stop_with_failure("timeout: pending requests were never granted");
    end
  endtask

  task automatic wait_outputs_quiet();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (out_valid_o != '0) begin
      @(negedge clk);
      waited++;
      if (waited > 8) stop_with_failure("timeout: outputs kept strobing after traffic ended");
    end
  endtask

  initial begin
    arst_n      = 1'b1;
    req         = '0;
    req_addr    = '0;
    req_payload = '0;
    gnt_at_edge = '0;
    rng_state   = 32'd46004;
    // Eight disjoint 256 KiB windows with one per 16 MiB block
    for (int unsigned i = 0; i < NumRules; i++) begin
      rule_map[i].idx        = RuleDst[i];
      rule_map[i].start_addr = addr_t'(i + 1) << 24;
      rule_map[i].end_addr   = (addr_t'(i + 1) << 24) + 32'h0004_0000;
    end
    // Reset edge lands before the first rising clock edge
    #1 arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    run_traffic(200, 0);
    drain_requests();
    run_traffic(40, 1);
    drain_requests();
    run_traffic(40, 2);
    drain_requests();
    wait_outputs_quiet();
    if (dir_seen != '1) begin
      stop_with_failure("not every output direction carried a flit");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* noc_router_top.sv */
/*
 * Routing front end of one mesh tile.
 * Each local requester is routed to one of five directions, one round-robin
 * arbiter per direction picks a winner, and the winning flit leaves on that
 * direction one cycle after its grant.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module noc_router_top (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic               [`NOC_NUM_REQ-1:0]     req_i,
  input  noc_pkg::addr_t     [`NOC_NUM_REQ-1:0]     req_addr_i,
  input  noc_pkg::payload_t  [`NOC_NUM_REQ-1:0]     req_payload_i,
  input  noc_pkg::addr_rule_t [`NOC_NUM_RULES-1:0]  addr_map_i,
  output logic               [`NOC_NUM_REQ-1:0]     gnt_o,
  output logic               [noc_pkg::NumDirs-1:0] out_valid_o,
  output noc_pkg::flit_t     [noc_pkg::NumDirs-1:0] out_flit_o
);

  import noc_pkg::*;

  // Per requester routing results
  xy_id_t     [`NOC_NUM_REQ-1:0] req_dst;
  route_dir_e [`NOC_NUM_REQ-1:0] req_dir;
  flit_t      [`NOC_NUM_REQ-1:0] req_flit;

  // Requests and grants split by direction
  logic [NumDirs-1:0][`NOC_NUM_REQ-1:0] dir_req;
  logic [NumDirs-1:0][`NOC_NUM_REQ-1:0] dir_gnt;

  for (genvar r = 0; r < `NOC_NUM_REQ; r++) begin : gen_req
    noc_route_comp #(
      .UseIdTable    ( `NOC_USE_ID_TABLE ),
      .XYAddrOffsetX ( `NOC_XY_OFFSET_X  ),
      .XYAddrOffsetY ( `NOC_XY_OFFSET_Y  )
    ) i_route_comp (
      .clk_i      ( clk_i         ),
      .arst_n_i   ( arst_n_i      ),
      .addr_i     ( req_addr_i[r] ),
      .addr_map_i ( addr_map_i    ),
      .valid_i    ( req_i[r]      ),
      .dst_o      ( req_dst[r]    )
    );

    noc_xy_route_select i_xy_route_select (
      .dst_i ( req_dst[r] ),
      .dir_o ( req_dir[r] )
    );

    // Flit carries its origin so the sink can tell requesters apart
    assign req_flit[r].dst     = req_dst[r];
    assign req_flit[r].src     = req_idx_t'(r);
    assign req_flit[r].payload = req_payload_i[r];

    // Steer the request to exactly one direction
    for (genvar d = 0; d < NumDirs; d++) begin : gen_steer
      assign dir_req[d][r] = req_i[r] && (req_dir[r] == route_dir_e'(d));
    end
  end

  for (genvar d = 0; d < NumDirs; d++) begin : gen_dir
    noc_out_arbiter i_out_arbiter (
      .clk_i    ( clk_i          ),
      .arst_n_i ( arst_n_i       ),
      .req_i    ( dir_req[d]     ),
      .flit_i   ( req_flit       ),
      .gnt_o    ( dir_gnt[d]     ),
      .valid_o  ( out_valid_o[d] ),
      .flit_o   ( out_flit_o[d]  )
    );
  end

  // Each requester sits on one direction, so the OR never merges two grants
  always_comb begin
    gnt_o = '0;
    for (int unsigned d = 0; d < NumDirs; d++) begin
      gnt_o |= dir_gnt[d];
    end
  end

endmodule

/* noc_out_arbiter.sv */
/*
 * Round-robin arbiter for one output direction.
 * Grants the first requester at or after the rotating pointer in the same
 * cycle, then registers the winning flit and strobes valid_o one cycle later.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module noc_out_arbiter (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic            [`NOC_NUM_REQ-1:0]   req_i,
  input  noc_pkg::flit_t  [`NOC_NUM_REQ-1:0]   flit_i,
  output logic            [`NOC_NUM_REQ-1:0]   gnt_o,
  output logic                                 valid_o,
  output noc_pkg::flit_t                       flit_o
);

  import noc_pkg::*;

  localparam int unsigned NumReq = `NOC_NUM_REQ;

  // Requester with the highest priority this cycle
  req_idx_t ptr_q, ptr_d;
  req_idx_t win_idx;
  logic     any_req;

  // Output stage
  logic     valid_q;
  flit_t    flit_q;

  // Search upward from the pointer, wrapping at NumReq
  always_comb begin
    int unsigned cand;
    any_req = 1'b0;
    win_idx = ptr_q;
    for (int unsigned k = 0; k < NumReq; k++) begin
      cand = (int'(ptr_q) + k) % NumReq;
      if (!any_req && req_i[cand]) begin
        any_req = 1'b1;
        win_idx = req_idx_t'(cand);
      end
    end
  end

  // One-hot grant, low when nobody asks
  always_comb begin
    gnt_o = '0;
    if (any_req) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // Pointer moves past the winner, stays put when idle
  always_comb begin
    ptr_d = ptr_q;
    if (any_req) begin
      ptr_d = (int'(win_idx) == NumReq - 1) ? '0 : req_idx_t'(win_idx + 1'b1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      ptr_q   <= ptr_d;
      // Single-cycle strobe, no stall possible
      valid_q <= any_req;
    end
  end

  // Payload register, loaded on a grant only
  always_ff @(posedge clk_i) begin
    if (any_req) begin
      flit_q <= flit_i[win_idx];
    end
  end

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

  // At most one winner per cycle
  a_gnt_onehot0 : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o))
    else $error("more than one grant on one direction: %b", gnt_o);

  // Never grant an idle requester
  a_gnt_has_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o & ~req_i) == '0)
    else $error("grant %b without matching request %b", gnt_o, req_i);

endmodule

/* noc_xy_route_select.sv */
/*
 * Dimension-ordered output selection for one flit.
 * Compares the destination with this tile's coordinate and picks
 * local, north, east, south or west. X is resolved before Y.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module noc_xy_route_select (
  input  noc_pkg::xy_id_t     dst_i,
  output noc_pkg::route_dir_e dir_o
);

  import noc_pkg::*;

  // This tile's position
  localparam coord_t LocalX = coord_t'(`NOC_LOCAL_X);
  localparam coord_t LocalY = coord_t'(`NOC_LOCAL_Y);

  // One bit per direction, indexed by route_dir_e
  logic [NumDirs-1:0] dir_hit;
  logic x_gt, x_lt, y_gt, y_lt;

  assign x_gt = dst_i.x > LocalX;
  assign x_lt = dst_i.x < LocalX;
  assign y_gt = dst_i.y > LocalY;
  assign y_lt = dst_i.y < LocalY;

  always_comb begin
    dir_hit           = '0;
    // X first
    dir_hit[DirEast]  = x_gt;
    dir_hit[DirWest]  = x_lt;
    // Y only once X matches
    dir_hit[DirNorth] = !x_gt && !x_lt && y_gt;
    dir_hit[DirSouth] = !x_gt && !x_lt && y_lt;
    // Arrived
    dir_hit[DirLocal] = !x_gt && !x_lt && !y_gt && !y_lt;
  end

  always_comb begin
    dir_o = DirLocal;
    for (int unsigned d = 0; d < NumDirs; d++) begin
      if (dir_hit[d]) begin
        dir_o = route_dir_e'(d);
      end
    end
    // Exactly one direction must claim every known destination
    if (!$isunknown(dst_i)) begin
      assert final ($onehot(dir_hit))
        else $error("ambiguous direction for destination (%0d,%0d)", dst_i.x, dst_i.y);
    end
  end

endmodule

/* noc_route_comp.sv */
/*
 * Route computation for one requester.
 * Turns a target address into a destination coordinate, either through the
 * programmable address map or by slicing X and Y out of fixed address bits.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module noc_route_comp #(
  // Use the address map, otherwise take the coordinate from the address bits
  parameter bit          UseIdTable    = `NOC_USE_ID_TABLE,
  // Lowest address bit of X in bit extraction mode
  parameter int unsigned XYAddrOffsetX = `NOC_XY_OFFSET_X,
  // Lowest address bit of Y in bit extraction mode
  parameter int unsigned XYAddrOffsetY = `NOC_XY_OFFSET_Y
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  noc_pkg::addr_t                            addr_i,
  input  noc_pkg::addr_rule_t [`NOC_NUM_RULES-1:0]  addr_map_i,
  input  logic                                      valid_i,
  output noc_pkg::xy_id_t                           dst_o
);

  import noc_pkg::*;

  if (UseIdTable) begin : gen_table_routing
    xy_id_t dec_idx;
    logic   dec_error;

    noc_addr_decode #(
      .NumRules    ( `NOC_NUM_RULES )
    ) i_addr_decode (
      .addr_i      ( addr_i    ),
      .addr_map_i  ( addr_map_i ),
      .idx_o       ( dec_idx   ),
      .dec_error_o ( dec_error )
    );

    assign dst_o = dec_idx;

    // A live request must hit a programmed rule
    a_no_dec_miss : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_i |-> !dec_error)
      else $error("request address %h hits no rule of the address map", addr_i);
  end else begin : gen_xy_bits_routing
    // Both coordinate fields must lie inside the address
    if (XYAddrOffsetX + $bits(coord_t) > $bits(addr_t) ||
        XYAddrOffsetY + $bits(coord_t) > $bits(addr_t)) begin : gen_offset_error
      $error("coordinate offsets exceed the address width");
    end

    assign dst_o.x = addr_i[XYAddrOffsetX +: $bits(coord_t)];
    assign dst_o.y = addr_i[XYAddrOffsetY +: $bits(coord_t)];
  end

endmodule

/* noc_addr_decode.sv */
/*
 * Address map decoder for route computation.
 * Scans the rule table and returns the coordinate of the first rule holding
 * the address. A miss returns coordinate 0 and raises the error flag.
 */

`timescale 1ns/100ps

`include "noc_config.svh"

module noc_addr_decode #(
  // Entries in the rule table
  parameter int unsigned NumRules = `NOC_NUM_RULES
) (
  input  noc_pkg::addr_t                    addr_i,
  input  noc_pkg::addr_rule_t [NumRules-1:0] addr_map_i,
  output noc_pkg::xy_id_t                   idx_o,
  output logic                              dec_error_o
);

  import noc_pkg::*;

  // Coordinate of the winning rule
  xy_id_t hit_idx;
  // Set once any rule has matched
  logic   hit;
  // Per rule range match
  logic [NumRules-1:0] rule_match;

  // Compare the address against every range in parallel
  always_comb begin
    for (int unsigned i = 0; i < NumRules; i++) begin
      // Half-open range, end address excluded
      rule_match[i] = (addr_i >= addr_map_i[i].start_addr) &&
                      (addr_i <  addr_map_i[i].end_addr);
    end
  end

  // Lowest matching index wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int unsigned i = 0; i < NumRules; i++) begin
      if (!hit && rule_match[i]) begin
        hit     = 1'b1;
        hit_idx = addr_map_i[i].idx;
      end
    end
  end

  assign idx_o       = hit_idx;
  // No rule claims this address
  assign dec_error_o = !hit;

endmodule

/* noc_pkg.sv */
/*
 * Shared types of the NoC tile routing front end.
 * Modules import it inside their body and use scoped names in their port lists.
 */

`include "noc_config.svh"

package noc_pkg;

  // Plain vectors with a meaning
  typedef logic [`NOC_ADDR_W-1:0]    addr_t;
  typedef logic [`NOC_COORD_W-1:0]   coord_t;
  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;
  // Names one local requester
  typedef logic [$clog2(`NOC_NUM_REQ)-1:0] req_idx_t;

  // Mesh coordinate of a tile
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_id_t;

  // One rule of the address map
  // Covers start_addr up to but not including end_addr
  typedef struct packed {
    xy_id_t idx;
    addr_t  start_addr;
    addr_t  end_addr;
  } addr_rule_t;

  // Flit as it leaves on an output direction
  typedef struct packed {
    xy_id_t   dst;
    req_idx_t src;
    payload_t payload;
  } flit_t;

  // Output directions of the router
  typedef enum logic [2:0] {
    DirLocal,
    DirNorth,
    DirEast,
    DirSouth,
    DirWest
  } route_dir_e;

  localparam int unsigned NumDirs = 5;

endpackage

/* noc_config.svh */
/*
 * Build-time configuration of the NoC tile routing front end.
 * Include this header wherever a width, a count or the tile position is needed.
 */

`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Bus widths
`define NOC_ADDR_W 32
`define NOC_COORD_W 3
`define NOC_PAYLOAD_W 32

// Local requesters and rule table entries
`define NOC_NUM_REQ 4
`define NOC_NUM_RULES 8

// Routing mode, 1 selects the address decode table
`define NOC_USE_ID_TABLE 1
// Lowest address bits of X and Y when coordinates come straight from the address
`define NOC_XY_OFFSET_X 24
`define NOC_XY_OFFSET_Y 28

// Position of this tile in the mesh
`define NOC_LOCAL_X 1
`define NOC_LOCAL_Y 1

`endif
